/* src/marble_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types, opcodes and fixed widths for the carrier board slice
// Modules pull these in with a wildcard import in their header
////////////////////////////////////////////////////////////////////////////
package marble_pkg;

	// SPI register frame is one command byte plus one data byte
	localparam int SPI_FRAME_BITS = 16;
	localparam int SPI_CNT_W = $clog2(SPI_FRAME_BITS) + 1;

	// White Rabbit DAC word and serial clock divider
	localparam int DAC_BITS = 16;
	localparam int DAC_CNT_W = $clog2(DAC_BITS);
	// tx_clk cycles per DAC SCLK period
	localparam int DAC_CLK_DIV = 4;
	localparam int DAC_DIV_W = $clog2(DAC_CLK_DIV);

	// TMDS symbols sent LSB first
	localparam int TMDS_SYM_BITS = 10;
	localparam int TMDS_CNT_W = $clog2(TMDS_SYM_BITS);
	localparam logic [TMDS_SYM_BITS-1:0] TMDS_DATA_SYM = 10'b1101010100;
	localparam logic [TMDS_SYM_BITS-1:0] TMDS_CLK_SYM = 10'b1111100000;

	// One GMII beat
	typedef struct packed {
		logic [7:0] d;
		logic en;
		logic er;
	} gmii_t;

	// Top bit of the SPI command byte
	typedef enum logic {
		SPI_WRITE = 1'b0,
		SPI_READ = 1'b1
	} spi_op_e;

	typedef enum logic [6:0] {
		REG_LED = 7'd0,
		REG_EXT_CONFIG = 7'd1,
		REG_DAC_LO = 7'd2,
		REG_DAC_HI = 7'd3,
		REG_DAC_GO = 7'd4,
		REG_RX_COUNT = 7'd5
	} reg_addr_e;

	// Single-cycle write strobe from the SPI slave
	typedef struct packed {
		logic we;
		reg_addr_e addr;
		logic [7:0] data;
	} reg_wr_t;

	// tmds_en is bit 0 and vcxo_off is bit 1
	typedef struct packed {
		logic [5:0] spare;
		logic vcxo_off;
		logic tmds_en;
	} ext_config_t;

	// sel low picks DAC1
	typedef struct packed {
		logic go;
		logic sel;
		logic [DAC_BITS-1:0] data;
	} dac_req_t;

	typedef enum logic [1:0] {
		DAC_IDLE,
		DAC_SHIFT,
		DAC_DONE
	} dac_state_e;

endpackage

/* src/rgmii_ddr.sv */
////////////////////////////////////////////////////////////////////////////
// RGMII pins to GMII beats and back at double data rate on tx_clk
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rgmii_ddr import marble_pkg::*; (
	input logic tx_clk,
	input logic rst,
	input logic [3:0] rgmii_rxd,
	input logic rgmii_rx_ctl,
	input gmii_t gmii_tx,
	output logic [3:0] rgmii_txd,
	output logic rgmii_tx_ctl,
	output logic rgmii_tx_clk,
	output gmii_t gmii_rx
);

	// Rising edge half of the rx beat
	logic [3:0] rxd_lo;
	logic ctl_rise;
	// Falling edge half
	logic [3:0] rxd_hi;
	logic ctl_fall;
	// Registered tx beat feeding the output mux
	gmii_t tx_q;

	// Low nibble and RX_DV
	always_ff @(posedge tx_clk) begin
		rxd_lo <= rgmii_rxd;
		ctl_rise <= rgmii_rx_ctl;
	end

	// High nibble and DV xor ER
	always_ff @(negedge tx_clk) begin
		rxd_hi <= rgmii_rxd;
		ctl_fall <= rgmii_rx_ctl;
	end

	// Whole byte one rising edge after the low nibble capture
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			gmii_rx <= '0;
		end else begin
			gmii_rx.d <= {rxd_hi, rxd_lo};
			gmii_rx.en <= ctl_rise;
			gmii_rx.er <= ctl_rise ^ ctl_fall;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			tx_q <= '0;
		end else begin
			tx_q <= gmii_tx;
		end
	end

	// Low nibble and en while the clock is high
	assign rgmii_txd = tx_clk ? tx_q.d[3:0] : tx_q.d[7:4];
	// Same ctl encoding as receive
	assign rgmii_tx_ctl = tx_clk ? tx_q.en : (tx_q.en ^ tx_q.er);
	// Forwarded clock stays in phase
	assign rgmii_tx_clk = tx_clk;

endmodule

/* src/mmc_spi_regs.sv */
////////////////////////////////////////////////////////////////////////////
// SPI mode 0 register slave for the board microcontroller
// SCLK is oversampled in tx_clk and frames are {op, addr} then data
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mmc_spi_regs import marble_pkg::*; (
	input logic tx_clk,
	input logic rst,
	input logic sclk,
	input logic csb,
	input logic mosi,
	input logic [7:0] rd_data,
	output logic miso,
	output reg_wr_t reg_wr,
	output reg_addr_e rd_addr
);

	// Two-flop synchronizers plus one more stage on sclk for edges
	logic [1:0] sclk_sync;
	logic [1:0] csb_sync;
	logic [1:0] mosi_sync;
	logic sclk_d;
	logic sclk_s;
	logic csb_s;
	logic mosi_s;
	logic sclk_rise;
	logic sclk_fall;
	// Bits received so far
	logic [SPI_FRAME_BITS-2:0] rx_sr;
	logic [SPI_CNT_W-1:0] bit_cnt;
	logic byte1_done;
	logic frame_done;
	// Read data on its way out
	logic [7:0] tx_sr;

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			sclk_sync <= '0;
			csb_sync <= '1;
			mosi_sync <= '0;
			sclk_d <= 1'b0;
		end else begin
			sclk_sync <= {sclk_sync[0], sclk};
			csb_sync <= {csb_sync[0], csb};
			mosi_sync <= {mosi_sync[0], mosi};
			sclk_d <= sclk_s;
		end
	end

	assign sclk_s = sclk_sync[1];
	assign csb_s = csb_sync[1];
	assign mosi_s = mosi_sync[1];
	assign sclk_rise = sclk_s & ~sclk_d;
	assign sclk_fall = ~sclk_s & sclk_d;

	// 8th and 16th rise of a live frame
	assign byte1_done = sclk_rise && !csb_s && bit_cnt == SPI_CNT_W'(7);
	assign frame_done = sclk_rise && !csb_s && bit_cnt == SPI_CNT_W'(SPI_FRAME_BITS - 1);

	// Address is complete as the 8th bit arrives
	assign rd_addr = reg_addr_e'({rx_sr[5:0], mosi_s});

	always_ff @(posedge tx_clk) begin
		if (sclk_rise && !csb_s) begin
			rx_sr <= {rx_sr[SPI_FRAME_BITS-3:0], mosi_s};
		end
	end

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			bit_cnt <= '0;
			reg_wr <= '0;
		end else begin
			reg_wr.we <= 1'b0;
			// csb high drops any partial frame
			if (csb_s) begin
				bit_cnt <= '0;
			end else if (sclk_rise && bit_cnt != SPI_CNT_W'(SPI_FRAME_BITS)) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			// Last data bit comes straight from mosi
			if (frame_done && spi_op_e'(rx_sr[14]) == SPI_WRITE) begin
				reg_wr.we <= 1'b1;
				reg_wr.addr <= reg_addr_e'(rx_sr[13:7]);
				reg_wr.data <= {rx_sr[6:0], mosi_s};
			end
		end
	end

	// Load on the 8th rise so MSB is out before byte 2
	// Shift on falls 9 to 15 so each rise sees the next bit
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			tx_sr <= '0;
		end else if (csb_s) begin
			tx_sr <= '0;
		end else if (byte1_done && spi_op_e'(rx_sr[6]) == SPI_READ) begin
			tx_sr <= rd_data;
		end else if (sclk_fall && bit_cnt > SPI_CNT_W'(8)
				&& bit_cnt != SPI_CNT_W'(SPI_FRAME_BITS)) begin
			tx_sr <= {tx_sr[6:0], 1'b0};
		end
	end

	assign miso = tx_sr[7];

	// No write strobe while a frame is still being clocked in
	a_no_wr_mid_frame: assert property (@(posedge tx_clk) disable iff (rst)
		(!csb_s && bit_cnt != SPI_CNT_W'(SPI_FRAME_BITS)) |-> !reg_wr.we);

endmodule

/* src/wr_dac_spi.sv */
////////////////////////////////////////////////////////////////////////////
// Sends one 16-bit word MSB first to White Rabbit DAC1 or DAC2
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wr_dac_spi import marble_pkg::*; (
	input logic tx_clk,
	input logic rst,
	input dac_req_t req,
	output logic dac_sclk,
	output logic dac_din,
	output logic dac1_sync,
	output logic dac2_sync,
	output logic busy
);

	dac_state_e state;
	logic [DAC_DIV_W-1:0] div_cnt;
	logic [DAC_CNT_W-1:0] bit_cnt;
	logic [DAC_BITS-1:0] shreg;
	logic sel_q;
	// Last tx_clk of one SCLK period
	logic period_end;

	assign period_end = div_cnt == DAC_DIV_W'(DAC_CLK_DIV - 1);

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			state <= DAC_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			sel_q <= 1'b0;
		end else begin
			case (state)
				DAC_IDLE: begin
					// go is only taken here so a busy request is dropped
					if (req.go) begin
						state <= DAC_SHIFT;
						sel_q <= req.sel;
						div_cnt <= '0;
						bit_cnt <= '0;
					end
				end
				DAC_SHIFT: begin
					div_cnt <= period_end ? '0 : div_cnt + 1'b1;
					if (period_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == DAC_CNT_W'(DAC_BITS - 1)) begin
							state <= DAC_DONE;
						end
					end
				end
				// One idle cycle with sync still low
				DAC_DONE: state <= DAC_IDLE;
				default: state <= DAC_IDLE;
			endcase
		end
	end

	// Word captured at go and shifted at each period boundary
	always_ff @(posedge tx_clk) begin
		if (state == DAC_IDLE && req.go) begin
			shreg <= req.data;
		end else if (state == DAC_SHIFT && period_end) begin
			shreg <= {shreg[DAC_BITS-2:0], 1'b0};
		end
	end

	assign busy = state != DAC_IDLE;
	// SCLK high for the first half so data moves with the rise
	assign dac_sclk = state == DAC_SHIFT && div_cnt < DAC_DIV_W'(DAC_CLK_DIV / 2);
	assign dac_din = state == DAC_SHIFT && shreg[DAC_BITS-1];
	assign dac1_sync = !(busy && !sel_q);
	assign dac2_sync = !(busy && sel_q);

	a_one_sync: assert property (@(posedge tx_clk) disable iff (rst)
		dac1_sync || dac2_sync);

	// Transfer length is fixed once started
	a_frame_len: assert property (@(posedge tx_clk) disable iff (rst)
		$rose(busy) |-> ##(DAC_BITS * DAC_CLK_DIV + 1) !busy);

endmodule

/* src/tmds_test.sv */
////////////////////////////////////////////////////////////////////////////
// Fixed TMDS pattern on three data lanes and the clock lane
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tmds_test import marble_pkg::*; (
	input logic tx_clk,
	input logic rst,
	input logic enable,
	output logic [3:0] tmds_p,
	output logic [3:0] tmds_n
);

	// Position inside the current symbol
	logic [TMDS_CNT_W-1:0] bit_idx;
	logic data_bit;
	logic clk_bit;
	logic last_bit;

	assign data_bit = TMDS_DATA_SYM[bit_idx];
	assign clk_bit = TMDS_CLK_SYM[bit_idx];
	assign last_bit = bit_idx == TMDS_CNT_W'(TMDS_SYM_BITS - 1);

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			bit_idx <= '0;
			tmds_p <= '0;
			tmds_n <= '0;
		end else if (enable) begin
			// Lane 3 is the clock lane
			tmds_p <= {clk_bit, {3{data_bit}}};
			tmds_n <= ~{clk_bit, {3{data_bit}}};
			bit_idx <= last_bit ? '0 : bit_idx + 1'b1;
		end else begin
			// Parked with the symbol counter at its start
			bit_idx <= '0;
			tmds_p <= '0;
			tmds_n <= '0;
		end
	end

	a_diff_pair: assert property (@(posedge tx_clk) disable iff (rst)
		enable |=> (tmds_n == ~tmds_p));

endmodule

/* src/marble_base.sv */
////////////////////////////////////////////////////////////////////////////
// Portable core with register bank and GMII loopback plus SPI, DAC, TMDS
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module marble_base import marble_pkg::*; (
	input logic tx_clk,
	input logic rst,
	input gmii_t gmii_rx,
	input logic sclk,
	input logic csb,
	input logic mosi,
	output gmii_t gmii_tx,
	output logic miso,
	output logic mmc_int,
	output logic phy_rstn,
	output logic [7:0] led,
	output ext_config_t ext_config,
	output logic dac_sclk,
	output logic dac_din,
	output logic dac1_sync,
	output logic dac2_sync,
	output logic [3:0] tmds_p,
	output logic [3:0] tmds_n
);

	reg_wr_t reg_wr;
	reg_addr_e rd_addr;
	logic [7:0] rd_data;
	logic [7:0] dac_lo;
	logic [7:0] dac_hi;
	// Received bytes with en set, wraps at 256
	logic [7:0] rx_count;
	dac_req_t dac_req;
	logic dac_busy;

	// PHY leaves reset on the first cycle after rst
	always_ff @(posedge tx_clk) begin
		phy_rstn <= !rst;
	end

	// One-cycle echo and byte count
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			gmii_tx <= '0;
			rx_count <= '0;
		end else begin
			gmii_tx <= gmii_rx;
			if (gmii_rx.en) begin
				rx_count <= rx_count + 8'd1;
			end
		end
	end

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			led <= '0;
			ext_config <= '0;
			dac_lo <= '0;
			dac_hi <= '0;
			dac_req <= '0;
		end else begin
			dac_req.go <= 1'b0;
			if (reg_wr.we) begin
				case (reg_wr.addr)
					REG_LED: led <= reg_wr.data;
					REG_EXT_CONFIG: ext_config <= ext_config_t'(reg_wr.data);
					REG_DAC_LO: dac_lo <= reg_wr.data;
					REG_DAC_HI: dac_hi <= reg_wr.data;
					REG_DAC_GO: begin
						// Launch with the held word and DAC select from bit 0
						dac_req.go <= 1'b1;
						dac_req.sel <= reg_wr.data[0];
						dac_req.data <= {dac_hi, dac_lo};
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Read mux answered in the same cycle
	always_comb begin
		case (rd_addr)
			REG_LED: rd_data = led;
			REG_EXT_CONFIG: rd_data = ext_config;
			REG_DAC_LO: rd_data = dac_lo;
			REG_DAC_HI: rd_data = dac_hi;
			REG_RX_COUNT: rd_data = rx_count;
			default: rd_data = '0;
		endcase
	end

	mmc_spi_regs spi (
		.tx_clk(tx_clk), .rst(rst), .sclk(sclk), .csb(csb), .mosi(mosi),
		.rd_data(rd_data), .miso(miso), .reg_wr(reg_wr), .rd_addr(rd_addr)
	);

	wr_dac_spi dac (
		.tx_clk(tx_clk), .rst(rst), .req(dac_req),
		.dac_sclk(dac_sclk), .dac_din(dac_din),
		.dac1_sync(dac1_sync), .dac2_sync(dac2_sync), .busy(dac_busy)
	);

	tmds_test tmds (
		.tx_clk(tx_clk), .rst(rst), .enable(ext_config.tmds_en),
		.tmds_p(tmds_p), .tmds_n(tmds_n)
	);

	// Tell the microcontroller a DAC write is in flight
	assign mmc_int = dac_busy;

endmodule

/* src/marble_top.sv */
////////////////////////////////////////////////////////////////////////////
// Board top tying RGMII, SPI, DAC, TMDS and LED pins to the core
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module marble_top import marble_pkg::*; (
	input logic tx_clk,
	input logic rst,
	input logic [3:0] rgmii_rxd,
	input logic rgmii_rx_ctl,
	input logic sclk,
	input logic csb,
	input logic mosi,
	output logic [3:0] rgmii_txd,
	output logic rgmii_tx_ctl,
	output logic rgmii_tx_clk,
	output logic phy_rstn,
	output logic miso,
	output logic mmc_int,
	output logic wr_dac_sclk,
	output logic wr_dac_din,
	output logic wr_dac1_sync,
	output logic wr_dac2_sync,
	output logic vcxo_en,
	output logic [3:0] tmds_p,
	output logic [3:0] tmds_n,
	output logic ld16,
	output logic ld17,
	output logic [7:0] pmod1
);

	gmii_t gmii_rx;
	gmii_t gmii_tx;
	logic [7:0] leds;
	ext_config_t ext_config;

	rgmii_ddr ddr (
		.tx_clk(tx_clk), .rst(rst),
		.rgmii_rxd(rgmii_rxd), .rgmii_rx_ctl(rgmii_rx_ctl), .gmii_tx(gmii_tx),
		.rgmii_txd(rgmii_txd), .rgmii_tx_ctl(rgmii_tx_ctl),
		.rgmii_tx_clk(rgmii_tx_clk), .gmii_rx(gmii_rx)
	);

	marble_base base (
		.tx_clk(tx_clk), .rst(rst), .gmii_rx(gmii_rx),
		.sclk(sclk), .csb(csb), .mosi(mosi),
		.gmii_tx(gmii_tx), .miso(miso), .mmc_int(mmc_int), .phy_rstn(phy_rstn),
		.led(leds), .ext_config(ext_config),
		.dac_sclk(wr_dac_sclk), .dac_din(wr_dac_din),
		.dac1_sync(wr_dac1_sync), .dac2_sync(wr_dac2_sync),
		.tmds_p(tmds_p), .tmds_n(tmds_n)
	);

	// Pmod carries the whole LED byte
	assign pmod1 = leds;
	assign ld16 = leds[0];
	assign ld17 = leds[1];
	// Network can switch the 20 MHz VCXO off
	assign vcxo_en = ~ext_config.vcxo_off;

endmodule

/* testbench/marble_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Random-stimulus testbench for marble_top with a register and byte model
// Drives RGMII, SPI frames and checks loopback, DAC words and TMDS lanes
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module marble_tb import marble_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int SEED = 47091;
	// tx_clk cycles per SCLK phase
	localparam int SCLK_HALF = 5;
	localparam int LOOP_BYTES = 200;
	localparam int N_REG = 6;
	localparam int N_DAC = 6;
	localparam int TMDS_CYCLES = 30;
	localparam int FRAME_CYCLES = 16 * (2 * SCLK_HALF + 1) + 2 * SCLK_HALF + 2;
	localparam int N_FRAMES = 4 * N_REG + 3 * N_DAC + 8;
	// Worst case is one byte per burst followed by a 7 beat gap
	localparam int LOOP_CYCLES = LOOP_BYTES * 8 + 10;
	localparam int WATCHDOG_CYCLES = 2 * (N_FRAMES * FRAME_CYCLES + LOOP_CYCLES + 200);
	localparam int DAC_WAIT = FRAME_CYCLES + DAC_BITS * DAC_CLK_DIV + 20;

	logic tx_clk;
	logic rst;
	logic [3:0] rgmii_rxd;
	logic rgmii_rx_ctl;
	logic sclk;
	logic csb;
	logic mosi;
	logic [3:0] rgmii_txd;
	logic rgmii_tx_ctl;
	logic rgmii_tx_clk;
	logic phy_rstn;
	logic miso;
	logic mmc_int;
	logic wr_dac_sclk;
	logic wr_dac_din;
	logic wr_dac1_sync;
	logic wr_dac2_sync;
	logic vcxo_en;
	logic [3:0] tmds_p;
	logic [3:0] tmds_n;
	logic ld16;
	logic ld17;
	logic [7:0] pmod1;

	// Register bank and counter model
	logic [7:0] led_model;
	ext_config_t cfg_model;
	logic [7:0] rx_model;
	int n_errors;
	int n_checks;

	marble_top uut (
		.tx_clk(tx_clk), .rst(rst), .rgmii_rxd(rgmii_rxd), .rgmii_rx_ctl(rgmii_rx_ctl),
		.sclk(sclk), .csb(csb), .mosi(mosi), .rgmii_txd(rgmii_txd),
		.rgmii_tx_ctl(rgmii_tx_ctl), .rgmii_tx_clk(rgmii_tx_clk), .phy_rstn(phy_rstn),
		.miso(miso), .mmc_int(mmc_int), .wr_dac_sclk(wr_dac_sclk), .wr_dac_din(wr_dac_din),
		.wr_dac1_sync(wr_dac1_sync), .wr_dac2_sync(wr_dac2_sync), .vcxo_en(vcxo_en),
		.tmds_p(tmds_p), .tmds_n(tmds_n), .ld16(ld16), .ld17(ld17), .pmod1(pmod1)
	);

	initial begin
		tx_clk = 1'b0;
		forever #(CLK_PERIOD / 2) tx_clk = ~tx_clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("Some tests failed");
		$finish;
	end

	task automatic report_fail(input string msg);
		n_errors++;
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] got);
		n_checks++;
		if (got !== exp) begin
			report_fail($sformatf("%s expected %h got %h", what, exp, got));
		end
	endtask

	task automatic check_gmii(input gmii_t exp, input gmii_t got);
		n_checks++;
		if (got !== exp) begin
			report_fail($sformatf("loopback expected d=%h en=%b er=%b got d=%h en=%b er=%b",
				exp.d, exp.en, exp.er, got.d, got.en, got.er));
		end
	endtask

	task automatic check_dac(input dac_req_t exp, input dac_req_t got);
		n_checks++;
		if (got !== exp) begin
			report_fail($sformatf("DAC expected sel=%b word=%h got sel=%b word=%h",
				exp.sel, exp.data, got.sel, got.data));
		end
	endtask

	// Mode 0 frame, MSB first, MISO taken just ahead of each rise
	task automatic spi_frame(input logic [15:0] frame, output logic [15:0] back);
		logic [15:0] out_sr;
		int i;
		out_sr = frame;
		back = '0;
		@(posedge tx_clk);
		csb <= 1'b0;
		repeat (SCLK_HALF) @(posedge tx_clk);
		for (i = 0; i < SPI_FRAME_BITS; i++) begin
			mosi <= out_sr[15];
			out_sr = {out_sr[14:0], 1'b0};
			repeat (SCLK_HALF) @(posedge tx_clk);
			@(negedge tx_clk);
			back = {back[14:0], miso};
			@(posedge tx_clk);
			sclk <= 1'b1;
			repeat (SCLK_HALF) @(posedge tx_clk);
			sclk <= 1'b0;
		end
		repeat (SCLK_HALF) @(posedge tx_clk);
		csb <= 1'b1;
		mosi <= 1'b0;
		repeat (SCLK_HALF) @(posedge tx_clk);
	endtask

	task automatic spi_write(input reg_addr_e addr, input logic [7:0] data);
		logic [15:0] back;
		spi_frame({SPI_WRITE, addr, data}, back);
	endtask

	task automatic spi_read(input reg_addr_e addr, output logic [7:0] data);
		logic [15:0] back;
		spi_frame({SPI_READ, addr, 8'h00}, back);
		data = back[7:0];
	endtask

	// LED pins and VCXO enable against the model
	task automatic check_pins();
		check_byte("pmod1", led_model, pmod1);
		check_byte("ld17 ld16", {6'b0, led_model[1:0]}, {6'b0, ld17, ld16});
		check_byte("vcxo_en", {7'b0, ~cfg_model.vcxo_off}, {7'b0, vcxo_en});
	endtask

	// Bursts of bytes with en set, then idle gaps, three idle beats to drain
	task automatic run_loopback();
		gmii_t stream[$];
		gmii_t beat;
		gmii_t got;
		logic [31:0] r;
		int n_en;
		int burst;
		int gap;
		int k;
		int i;
		n_en = 0;
		while (n_en < LOOP_BYTES) begin
			r = $urandom();
			burst = 1 + int'(r[3:0]);
			gap = int'(r[6:4]);
			for (k = 0; k < burst && n_en < LOOP_BYTES; k++) begin
				r = $urandom();
				beat.d = r[7:0];
				beat.en = 1'b1;
				beat.er = r[12:8] == 5'd0;
				stream.push_back(beat);
				n_en++;
			end
			for (k = 0; k < gap; k++) begin
				r = $urandom();
				beat.d = r[7:0];
				beat.en = 1'b0;
				beat.er = 1'b0;
				stream.push_back(beat);
			end
		end
		for (k = 0; k < 3; k++) begin
			stream.push_back('0);
		end
		rx_model = rx_model + 8'(n_en);
		// DDR pins so the low half leads its rising capture by half a cycle
		@(negedge tx_clk);
		rgmii_rxd <= stream[0].d[3:0];
		rgmii_rx_ctl <= stream[0].en;
		for (i = 0; i < stream.size(); i++) begin
			@(posedge tx_clk);
			rgmii_rxd <= stream[i].d[7:4];
			rgmii_rx_ctl <= stream[i].en ^ stream[i].er;
			#2;
			got.d[3:0] = rgmii_txd;
			got.en = rgmii_tx_ctl;
			// Forwarded clock follows tx_clk
			check_byte("rgmii_tx_clk high phase", 8'h01, {7'b0, rgmii_tx_clk});
			@(negedge tx_clk);
			rgmii_rxd <= (i + 1 < stream.size()) ? stream[i + 1].d[3:0] : 4'h0;
			rgmii_rx_ctl <= (i + 1 < stream.size()) ? stream[i + 1].en : 1'b0;
			#2;
			got.d[7:4] = rgmii_txd;
			got.er = got.en ^ rgmii_tx_ctl;
			check_byte("rgmii_tx_clk low phase", 8'h00, {7'b0, rgmii_tx_clk});
			// Pin to pin latency is three cycles
			if (i >= 3) begin
				check_gmii(stream[i - 3], got);
			end
		end
	endtask

	// Follows one DAC frame from sync low to sync high
	task automatic capture_dac(output dac_req_t got, output int low_cycles);
		int wait_cnt;
		logic sel;
		logic prev_sclk;
		got = '0;
		low_cycles = 0;
		wait_cnt = 0;
		prev_sclk = 1'b0;
		@(negedge tx_clk);
		while (wr_dac1_sync && wr_dac2_sync && wait_cnt < DAC_WAIT) begin
			@(negedge tx_clk);
			wait_cnt++;
		end
		if (wr_dac1_sync && wr_dac2_sync) begin
			n_errors++;
			$display("DAC frame never started, both sync lines stayed high");
		end else begin
			sel = wr_dac1_sync;
			got.go = 1'b1;
			got.sel = sel;
			while ((sel ? !wr_dac2_sync : !wr_dac1_sync) && low_cycles < DAC_WAIT) begin
				low_cycles++;
				if (sel ? !wr_dac1_sync : !wr_dac2_sync) begin
					report_fail("unselected DAC sync went low");
				end
				if (!mmc_int) begin
					report_fail("mmc_int low during DAC frame");
				end
				// Data is stable at the SCLK fall
				if (prev_sclk && !wr_dac_sclk) begin
					got.data = {got.data[DAC_BITS-2:0], wr_dac_din};
				end
				prev_sclk = wr_dac_sclk;
				@(negedge tx_clk);
			end
		end
	endtask

	// First nonzero n marks symbol bit 0 on every lane
	task automatic watch_tmds();
		logic [3:0] idx;
		logic [3:0] exp_p;
		int k;
		k = 0;
		@(negedge tx_clk);
		while (tmds_n == 4'h0 && k < FRAME_CYCLES + 20) begin
			@(negedge tx_clk);
			k++;
		end
		if (tmds_n == 4'h0) begin
			n_errors++;
			$display("TMDS lanes never started after enable");
		end else begin
			idx = 4'd0;
			for (k = 0; k < TMDS_CYCLES; k++) begin
				exp_p = {TMDS_CLK_SYM[idx], {3{TMDS_DATA_SYM[idx]}}};
				check_byte("TMDS n and p", {~exp_p, exp_p}, {tmds_n, tmds_p});
				idx = (idx == 4'(TMDS_SYM_BITS - 1)) ? 4'd0 : idx + 4'd1;
				@(negedge tx_clk);
			end
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0] rd;
		dac_req_t exp_dac;
		dac_req_t got_dac;
		int low_cycles;
		int i;
		rst = 1'b1;
		rgmii_rxd = 4'h0;
		rgmii_rx_ctl = 1'b0;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		n_errors = 0;
		n_checks = 0;
		led_model = '0;
		cfg_model = '0;
		rx_model = '0;
		void'($urandom(SEED));

		// Reset values while rst is still high
		repeat (2) @(posedge tx_clk);
		@(negedge tx_clk);
		check_byte("reset control pins", 8'b0110_0100, {phy_rstn, wr_dac1_sync,
			wr_dac2_sync, wr_dac_sclk, miso, vcxo_en, rgmii_tx_ctl, mmc_int});
		check_byte("reset TMDS", 8'h00, {tmds_n, tmds_p});
		check_pins();
		@(posedge tx_clk);
		rst <= 1'b0;
		@(posedge tx_clk);
		@(negedge tx_clk);
		check_byte("phy_rstn after reset", 8'h01, {7'b0, phy_rstn});

		run_loopback();
		spi_read(REG_RX_COUNT, rd);
		check_byte("RX_COUNT", rx_model, rd);

		for (i = 0; i < N_REG; i++) begin
			r = $urandom();
			led_model = r[7:0];
			cfg_model = ext_config_t'(r[15:8]);
			spi_write(REG_LED, led_model);
			spi_write(REG_EXT_CONFIG, cfg_model);
			spi_read(REG_LED, rd);
			check_byte("LED readback", led_model, rd);
			spi_read(REG_EXT_CONFIG, rd);
			check_byte("EXT_CONFIG readback", cfg_model, rd);
			check_pins();
		end

		for (i = 0; i < N_DAC; i++) begin
			r = $urandom();
			exp_dac.go = 1'b1;
			exp_dac.sel = r[16];
			exp_dac.data = r[15:0];
			spi_write(REG_DAC_LO, r[7:0]);
			spi_write(REG_DAC_HI, r[15:8]);
			fork
				spi_write(REG_DAC_GO, r[23:16]);
				capture_dac(got_dac, low_cycles);
			join
			check_dac(exp_dac, got_dac);
			if (low_cycles != DAC_BITS * DAC_CLK_DIV + 1) begin
				report_fail($sformatf("DAC sync low for %0d cycles", low_cycles));
			end
		end
		spi_read(REG_DAC_HI, rd);
		check_byte("DAC_HI readback", exp_dac.data[15:8], rd);
		spi_read(REG_DAC_GO, rd);
		check_byte("DAC_GO readback", 8'h00, rd);

		// Start TMDS from a parked state
		cfg_model = '0;
		spi_write(REG_EXT_CONFIG, cfg_model);
		check_byte("TMDS parked", 8'h00, {tmds_n, tmds_p});
		cfg_model = ext_config_t'(8'h01);
		fork
			spi_write(REG_EXT_CONFIG, cfg_model);
			watch_tmds();
		join
		cfg_model = '0;
		spi_write(REG_EXT_CONFIG, cfg_model);
		repeat (2) @(negedge tx_clk);
		check_byte("TMDS after disable", 8'h00, {tmds_n, tmds_p});
		check_pins();

		$display("Checks: %0d  errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
src/marble_pkg.sv
src/rgmii_ddr.sv
src/mmc_spi_regs.sv
src/wr_dac_spi.sv
src/tmds_test.sv
src/marble_base.sv
src/marble_top.sv
testbench/marble_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the marble testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module marble_tb \
	-f filelist.f \
	--Mdir obj_dir -o marble_sim

./obj_dir/marble_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
	echo "Simulation PASSED"
	exit 0
fi
echo "Simulation FAILED"
exit 1
